// File: axis2axi.f
design/axis2axi_pkg.sv
design/axi_burst_len.sv
design/axis2axi_out.sv
design/axis2axi_in.sv
design/axis2axi.sv
sim/axi_mem_model.sv
sim/axis2axi_props.sv
sim/axis2axi_tb.sv

// File: Bender.yml
package:
  name: axis2axi

sources:
  - design/axis2axi_pkg.sv
  - design/axi_burst_len.sv
  - design/axis2axi_out.sv
  - design/axis2axi_in.sv
  - design/axis2axi.sv
  - target: simulation
    files:
      - sim/axi_mem_model.sv
      - sim/axis2axi_props.sv
      - sim/axis2axi_tb.sv

// File: sim/axis2axi_stim.txt
# columns: name, op, start byte address, length in words, data seed (numbers in hex)
# W writes seed plus k to word k, R reads back and checks the shadow memory
wr_short   W 000100 05 11110000
rd_short   R 000100 05 00000000
wr_page    W 000ff4 14 22220000
rd_page    R 000ff4 14 00000000
wr_long    W 012340 46 33330000
rd_long    R 012340 46 00000000
rd_part    R 012348 09 00000000
wr_zero    W 000200 00 00000000
rd_zero    R 000200 00 00000000
wr_edge    W 0ffff0 28 44440000
rd_edge    R 0ffff0 28 00000000
rd_single  R 0ffffc 01 00000000

// File: sim/axis2axi_tb.sv
`default_nettype none

module axis2axi_tb
   import axis2axi_pkg::*;
();

   localparam int TIMEOUT = 2000;

   logic      clk;
   logic      rst;
   xfer_cfg_t cfg_out;
   xfer_cfg_t cfg_in;
   logic      cfg_out_valid;
   logic      cfg_out_ready;
   logic      cfg_in_valid;
   logic      cfg_in_ready;
   data_t     axis_out_data;
   data_t     axis_in_data;
   logic      axis_out_valid;
   logic      axis_out_ready;
   logic      axis_in_valid;
   logic      axis_in_ready;
   axi_ax_t   ar;
   axi_ax_t   aw;
   axi_beat_t r;
   axi_beat_t w;
   logic      arvalid;
   logic      arready;
   logic      rvalid;
   logic      rready;
   logic      awvalid;
   logic      awready;
   logic      wvalid;
   logic      wready;
   logic      bvalid;
   logic      bready;

   data_t     shadow [addr_t];
   axi_ax_t   ar_seen [$];
   axi_ax_t   aw_seen [$];
   axi_ax_t   exp_ax [$];
   data_t     rx_data [$];
   int        in_beats = 0;
   int        b_count = 0;
   int        errors = 0;
   int        tests = 0;
   int        failed = 0;
   bit        aborted = 1'b0;
   logic [8*16-1:0] name;

   axis2axi DUT (
      .clk_i(clk), .rst_i(rst),
      .cfg_out_i(cfg_out), .cfg_out_valid_i(cfg_out_valid), .cfg_out_ready_o(cfg_out_ready),
      .cfg_in_i(cfg_in), .cfg_in_valid_i(cfg_in_valid), .cfg_in_ready_o(cfg_in_ready),
      .axis_out_data_o(axis_out_data), .axis_out_valid_o(axis_out_valid),
      .axis_out_ready_i(axis_out_ready),
      .axis_in_data_i(axis_in_data), .axis_in_valid_i(axis_in_valid),
      .axis_in_ready_o(axis_in_ready),
      .ar_o(ar), .arvalid_o(arvalid), .arready_i(arready),
      .r_i(r), .rvalid_i(rvalid), .rready_o(rready),
      .aw_o(aw), .awvalid_o(awvalid), .awready_i(awready),
      .w_o(w), .wvalid_o(wvalid), .wready_i(wready),
      .bvalid_i(bvalid), .bready_o(bready)
   );

   axi_mem_model u_mem (
      .clk_i(clk), .rst_i(rst),
      .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
      .r_o(r), .rvalid_o(rvalid), .rready_i(rready),
      .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
      .w_i(w), .wvalid_i(wvalid), .wready_o(wready),
      .bvalid_o(bvalid), .bready_i(bready)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   // Port monitor
   always @(posedge clk) begin
      if (arvalid && arready) ar_seen.push_back(ar);
      if (awvalid && awready) aw_seen.push_back(aw);
      if (axis_out_valid && axis_out_ready) rx_data.push_back(axis_out_data);
      if (axis_in_valid && axis_in_ready) in_beats++;
      if (bvalid && bready) b_count++;
   end

   // Random back-pressure on the outgoing stream
   always @(negedge clk) begin
      if (!rst) axis_out_ready = ($urandom_range(3) != 0);
   end

   task automatic check_data(input data_t exp, input data_t act);
      if (act !== exp) begin
         $display("ERROR %0s: expected data %h, got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_ax(input axi_ax_t exp, input axi_ax_t act);
      if (act !== exp) begin
         $display("ERROR %0s: expected addr %h len %0d, got addr %h len %0d",
                  name, exp.addr, exp.len, act.addr, act.len);
         errors++;
      end
   endtask

   task automatic check_count(input wcount_t exp, input wcount_t act);
      if (act !== exp) begin
         $display("ERROR %0s: expected count %0d, got %0d", name, exp, act);
         errors++;
      end
   endtask

   function automatic bit out_of_time(input int cnt, input string what);
      if (cnt < TIMEOUT) return 1'b0;
      $display("%0s: timed out waiting for %0s", name, what);
      errors++;
      aborted = 1'b1;
      return 1'b1;
   endfunction

   function automatic data_t expected_word(input addr_t a);
      return shadow.exists(a) ? shadow[a] : data_t'({8'h5a, a});
   endfunction

   // Burst list from the sizing rule
   task automatic predict_bursts(input addr_t addr, input wcount_t len);
      axi_ax_t req;
      int      left;
      int      n;
      int      room;
      exp_ax.delete();
      left = int'(len);
      while (left > 0) begin
         n = (left < BURST_SIZE) ? left : BURST_SIZE;
         room = PAGE_WORDS - int'(addr % 4096) / 4;
         if (n > room) n = room;
         req.addr = addr;
         req.len = axlen_t'(n - 1);
         exp_ax.push_back(req);
         addr = addr + addr_t'(4 * n);
         left = left - n;
      end
   endtask

   task automatic compare_bursts(input bit is_read);
      int n_seen;
      n_seen = is_read ? ar_seen.size() : aw_seen.size();
      check_count(wcount_t'(exp_ax.size()), wcount_t'(n_seen));
      foreach (exp_ax[i]) begin
         if (i < n_seen) check_ax(exp_ax[i], is_read ? ar_seen[i] : aw_seen[i]);
      end
      // The other direction stays silent
      check_count(wcount_t'(0), wcount_t'(is_read ? aw_seen.size() : ar_seen.size()));
   endtask

   task automatic send_cfg(input bit is_write, input addr_t addr, input wcount_t len);
      int cnt;
      cfg_in.addr = addr;
      cfg_in.length = len;
      cfg_out = cfg_in;
      cfg_in_valid = is_write;
      cfg_out_valid = !is_write;
      cnt = 0;
      while (!(is_write ? cfg_in_ready : cfg_out_ready)) begin
         @(negedge clk);
         cnt++;
         if (out_of_time(cnt, "configuration ready")) return;
      end
      @(negedge clk);
      cfg_in_valid = 1'b0;
      cfg_out_valid = 1'b0;
   endtask

   task automatic write_xfer(input addr_t addr, input wcount_t len, input data_t seed);
      int cnt;
      send_cfg(1'b1, addr, len);
      for (int k = 0; k < len && !aborted; k++) begin
         axis_in_valid = 1'b0;
         if ($urandom_range(3) == 0) @(negedge clk);
         axis_in_data = seed + data_t'(k);
         axis_in_valid = 1'b1;
         cnt = 0;
         while (in_beats <= k) begin
            @(negedge clk);
            cnt++;
            if (cfg_in_ready) begin
               $display("%0s: write configuration ready rose before the last beat", name);
               errors++;
            end
            if (out_of_time(cnt, "an incoming stream beat")) return;
         end
         shadow[addr + addr_t'(4 * k)] = seed + data_t'(k);
      end
      axis_in_valid = 1'b0;
      cnt = 0;
      while (!cfg_in_ready && !aborted) begin
         @(negedge clk);
         cnt++;
         if (out_of_time(cnt, "the end of the write")) return;
      end
      // Ready may only rise after the final B
      check_count(wcount_t'(exp_ax.size()), wcount_t'(b_count));
   endtask

   task automatic read_xfer(input addr_t addr, input wcount_t len);
      int cnt;
      send_cfg(1'b0, addr, len);
      cnt = 0;
      while (rx_data.size() < len && !aborted) begin
         if (cfg_out_ready) begin
            $display("%0s: read configuration ready high before the last beat", name);
            errors++;
         end
         @(negedge clk);
         cnt++;
         if (out_of_time(cnt, "outgoing stream beats")) return;
      end
      cnt = 0;
      while (!cfg_out_ready && !aborted) begin
         @(negedge clk);
         cnt++;
         if (out_of_time(cnt, "the end of the read")) return;
      end
   endtask

   task automatic run_test(input logic [7:0] op, input addr_t addr, input wcount_t len,
                           input data_t seed);
      int err0;
      err0 = errors;
      ar_seen.delete();
      aw_seen.delete();
      rx_data.delete();
      in_beats = 0;
      b_count = 0;
      predict_bursts(addr, len);
      if (op == "W") write_xfer(addr, len, seed);
      else read_xfer(addr, len);
      // Quiet window to catch stray traffic
      repeat (8) @(negedge clk);
      if (!aborted) begin
         compare_bursts(op != "W");
         check_count(wcount_t'((op == "W") ? 0 : len), wcount_t'(rx_data.size()));
         foreach (rx_data[k]) check_data(expected_word(addr + addr_t'(4 * k)), rx_data[k]);
      end
      tests++;
      if (errors != err0) failed++;
      $display("%0s %0s", name, (errors == err0) ? "ok" : "failing");
   endtask

   initial begin
      int              fd;
      logic [8*96-1:0] line;
      logic [7:0]      op;
      addr_t           addr;
      wcount_t         len;
      data_t           seed;
      void'($urandom(32'h160bb256));
      rst = 1'b1;
      cfg_out = '0;
      cfg_in = '0;
      cfg_out_valid = 1'b0;
      cfg_in_valid = 1'b0;
      axis_out_ready = 1'b0;
      axis_in_data = '0;
      axis_in_valid = 1'b0;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      fd = $fopen("sim/axis2axi_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file");
         errors++;
      end else begin
         while (!aborted && $fgets(line, fd) > 0) begin
            if ($sscanf(line, "%s %s %h %h %h", name, op, addr, len, seed) == 5) begin
               run_test(op, addr, len, seed);
            end
         end
         $fclose(fd);
      end
      $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0 && tests > 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/axis2axi_props.sv
`default_nettype none

module axis2axi_props
   import axis2axi_pkg::*;
(
   input logic      clk_i,
   input logic      rst_i,
   input axi_ax_t   ar_o,
   input logic      arvalid_o,
   input logic      arready_i,
   input axi_ax_t   aw_o,
   input logic      awvalid_o,
   input logic      awready_i,
   input axi_beat_t w_o,
   input logic      wvalid_o,
   input logic      wready_i
);

   // At most BURST_SIZE beats, last beat in the same 4 KB page
   function automatic logic legal_burst(input axi_ax_t req);
      return (int'(req.len) < BURST_SIZE) &&
             ((int'(req.addr[11:2]) + int'(req.len)) < PAGE_WORDS);
   endfunction

   ar_legal: assert property (@(posedge clk_i) disable iff (rst_i)
      arvalid_o |-> legal_burst(ar_o))
      else $error("AR burst too long or crossing a 4 KB boundary");

   aw_legal: assert property (@(posedge clk_i) disable iff (rst_i)
      awvalid_o |-> legal_burst(aw_o))
      else $error("AW burst too long or crossing a 4 KB boundary");

   ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
      else $error("AR request dropped or changed before arready");

   aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o))
      else $error("AW request dropped or changed before awready");

   w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_o && !wready_i |=> wvalid_o && $stable(w_o))
      else $error("W beat dropped or changed before wready");

endmodule

bind axis2axi axis2axi_props u_props (.*);

`default_nettype wire

// File: sim/axi_mem_model.sv
`default_nettype none

module axi_mem_model
   import axis2axi_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  axi_ax_t   ar_i,
   input  logic      arvalid_i,
   output logic      arready_o,
   output axi_beat_t r_o,
   output logic      rvalid_o,
   input  logic      rready_i,
   input  axi_ax_t   aw_i,
   input  logic      awvalid_i,
   output logic      awready_o,
   input  axi_beat_t w_i,
   input  logic      wvalid_i,
   output logic      wready_o,
   output logic      bvalid_o,
   input  logic      bready_i
);

   data_t mem [addr_t];
   addr_t rd_addr;
   addr_t wr_addr;
   int    rd_left;
   logic  rd_busy;
   logic  wr_busy;
   logic  b_pend;
   logic  r_taken;

   function automatic data_t read_word(input addr_t a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      // Unwritten words read back a pattern of their address
      return data_t'({8'h5a, a});
   endfunction

   initial begin
      arready_o = 1'b0;
      rvalid_o  = 1'b0;
      r_o       = '0;
      awready_o = 1'b0;
      wready_o  = 1'b0;
      bvalid_o  = 1'b0;
   end

   // Handshakes are taken at the rising edge
   always @(posedge clk_i) begin
      if (rst_i) begin
         rd_busy <= 1'b0;
         wr_busy <= 1'b0;
         b_pend  <= 1'b0;
         r_taken <= 1'b0;
      end else begin
         r_taken <= rvalid_o && rready_i;
         if (arvalid_i && arready_o) begin
            rd_addr <= ar_i.addr;
            rd_left <= int'(ar_i.len) + 1;
            rd_busy <= 1'b1;
         end
         if (rvalid_o && rready_i) begin
            rd_addr <= rd_addr + addr_t'(4);
            rd_left <= rd_left - 1;
            rd_busy <= (rd_left > 1);
         end
         if (awvalid_i && awready_o) begin
            wr_addr <= aw_i.addr;
            wr_busy <= 1'b1;
         end
         if (wvalid_i && wready_o) begin
            mem[wr_addr] = w_i.data;
            wr_addr <= wr_addr + addr_t'(4);
            b_pend  <= w_i.last;
         end
         if (bvalid_o && bready_i) begin
            b_pend  <= 1'b0;
            wr_busy <= 1'b0;
         end
      end
   end

   // Outputs change at the falling edge, valids held until taken
   always @(negedge clk_i) begin
      if (rst_i) begin
         arready_o <= 1'b0;
         rvalid_o  <= 1'b0;
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         bvalid_o  <= 1'b0;
      end else begin
         arready_o <= !rd_busy && ($urandom_range(3) != 0);
         rvalid_o  <= rd_busy && ((rvalid_o && !r_taken) || ($urandom_range(3) != 0));
         r_o.data  <= rd_busy ? read_word(rd_addr) : '0;
         r_o.last  <= (rd_left == 1);
         awready_o <= !wr_busy && ($urandom_range(3) != 0);
         wready_o  <= wr_busy && !b_pend && ($urandom_range(3) != 0);
         bvalid_o  <= b_pend && (bvalid_o || ($urandom_range(3) != 0));
      end
   end

endmodule

`default_nettype wire

// File: design/axis2axi.sv
`default_nettype none

module axis2axi
   import axis2axi_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,

   // Read and write configuration
   input  xfer_cfg_t cfg_out_i,
   input  logic      cfg_out_valid_i,
   output logic      cfg_out_ready_o,
   input  xfer_cfg_t cfg_in_i,
   input  logic      cfg_in_valid_i,
   output logic      cfg_in_ready_o,

   // Streams
   output data_t     axis_out_data_o,
   output logic      axis_out_valid_o,
   input  logic      axis_out_ready_i,
   input  data_t     axis_in_data_i,
   input  logic      axis_in_valid_i,
   output logic      axis_in_ready_o,

   // AXI master
   output axi_ax_t   ar_o,
   output logic      arvalid_o,
   input  logic      arready_i,
   input  axi_beat_t r_i,
   input  logic      rvalid_i,
   output logic      rready_o,
   output axi_ax_t   aw_o,
   output logic      awvalid_o,
   input  logic      awready_i,
   output axi_beat_t w_o,
   output logic      wvalid_o,
   input  logic      wready_i,
   input  logic      bvalid_i,
   output logic      bready_o
);

   // Memory to stream
   axis2axi_out u_out (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .cfg_i        (cfg_out_i),
      .cfg_valid_i  (cfg_out_valid_i),
      .cfg_ready_o  (cfg_out_ready_o),
      .axis_data_o  (axis_out_data_o),
      .axis_valid_o (axis_out_valid_o),
      .axis_ready_i (axis_out_ready_i),
      .ar_o         (ar_o),
      .arvalid_o    (arvalid_o),
      .arready_i    (arready_i),
      .r_i          (r_i),
      .rvalid_i     (rvalid_i),
      .rready_o     (rready_o)
   );

   // Stream to memory
   axis2axi_in u_in (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .cfg_i        (cfg_in_i),
      .cfg_valid_i  (cfg_in_valid_i),
      .cfg_ready_o  (cfg_in_ready_o),
      .axis_data_i  (axis_in_data_i),
      .axis_valid_i (axis_in_valid_i),
      .axis_ready_o (axis_in_ready_o),
      .aw_o         (aw_o),
      .awvalid_o    (awvalid_o),
      .awready_i    (awready_i),
      .w_o          (w_o),
      .wvalid_o     (wvalid_o),
      .wready_i     (wready_i),
      .bvalid_i     (bvalid_i),
      .bready_o     (bready_o)
   );

endmodule

`default_nettype wire

// File: design/axis2axi_in.sv
`default_nettype none

module axis2axi_in
   import axis2axi_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,

   // Configuration
   input  xfer_cfg_t cfg_i,
   input  logic      cfg_valid_i,
   output logic      cfg_ready_o,

   // Incoming stream
   input  data_t     axis_data_i,
   input  logic      axis_valid_i,
   output logic      axis_ready_o,

   // AXI write channels
   output axi_ax_t   aw_o,
   output logic      awvalid_o,
   input  logic      awready_i,
   output axi_beat_t w_o,
   output logic      wvalid_o,
   input  logic      wready_i,
   input  logic      bvalid_i,
   output logic      bready_o
);

   wr_state_e state;
   wr_state_e state_nxt;

   addr_t     cur_addr;
   addr_t     addr_nxt;
   wcount_t   cur_len;
   wcount_t   len_nxt;
   beats_t    burst_beats;
   beats_t    next_beats;
   beats_t    beat_cnt;

   logic      in_data;
   logic      w_fire;
   logic      w_last;

   axi_burst_len u_burst_len (
      .addr_i      (cur_addr),
      .remaining_i (cur_len),
      .beats_o     (next_beats)
   );

   assign in_data = (state == WR_DATA);

   // Stream beats go straight onto W
   assign wvalid_o     = in_data && axis_valid_i;
   assign axis_ready_o = in_data && wready_i;
   assign w_fire       = in_data && axis_valid_i && wready_i;

   assign w_last     = (beat_cnt == burst_beats - beats_t'(1));
   assign w_o.data   = axis_data_i;
   assign w_o.last   = w_last;

   assign cfg_ready_o = (state == WR_WAIT_START);

   assign awvalid_o   = (state == WR_ADDRESS);
   assign aw_o.addr   = cur_addr;
   assign aw_o.len    = axlen_t'(burst_beats - beats_t'(1));

   assign bready_o    = (state == WR_RESPONSE);

   always_comb begin
      state_nxt = state;
      addr_nxt  = cur_addr;
      len_nxt   = cur_len;

      unique case (state)
         WR_WAIT_START: begin
            if (cfg_valid_i) begin
               addr_nxt = cfg_i.addr;
               len_nxt  = cfg_i.length;
               if (cfg_i.length != '0) begin
                  state_nxt = WR_BEGIN_LOCAL;
               end
            end
         end
         WR_BEGIN_LOCAL: begin
            len_nxt   = cur_len - wcount_t'(next_beats);
            state_nxt = WR_ADDRESS;
         end
         WR_ADDRESS: begin
            if (awready_i) begin
               state_nxt = WR_DATA;
            end
         end
         WR_DATA: begin
            if (w_fire && w_last) begin
               state_nxt = WR_RESPONSE;
            end
         end
         WR_RESPONSE: begin
            // Response code is ignored
            if (bvalid_i) begin
               addr_nxt = cur_addr + addr_t'({burst_beats, 2'b00});
               if (cur_len == '0) begin
                  state_nxt = WR_WAIT_START;
               end else begin
                  state_nxt = WR_BEGIN_LOCAL;
               end
            end
         end
         default: begin
            state_nxt = WR_WAIT_START;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state    <= WR_WAIT_START;
         beat_cnt <= '0;
      end else begin
         state <= state_nxt;
         // Restart the count for every burst
         if (state == WR_BEGIN_LOCAL) begin
            beat_cnt <= '0;
         end else if (w_fire) begin
            beat_cnt <= beat_cnt + beats_t'(1);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      cur_addr <= addr_nxt;
      cur_len  <= len_nxt;
      if (state == WR_BEGIN_LOCAL) begin
         burst_beats <= next_beats;
      end
   end

endmodule

`default_nettype wire

// File: design/axis2axi_out.sv
`default_nettype none

module axis2axi_out
   import axis2axi_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,

   // Configuration
   input  xfer_cfg_t cfg_i,
   input  logic      cfg_valid_i,
   output logic      cfg_ready_o,

   // Outgoing stream
   output data_t     axis_data_o,
   output logic      axis_valid_o,
   input  logic      axis_ready_i,

   // AXI read channels
   output axi_ax_t   ar_o,
   output logic      arvalid_o,
   input  logic      arready_i,
   input  axi_beat_t r_i,
   input  logic      rvalid_i,
   output logic      rready_o
);

   rd_state_e state;
   rd_state_e state_nxt;

   addr_t     cur_addr;
   addr_t     addr_nxt;
   wcount_t   cur_len;
   wcount_t   len_nxt;
   beats_t    burst_beats;
   beats_t    next_beats;

   logic      in_burst;
   logic      r_done;

   axi_burst_len u_burst_len (
      .addr_i      (cur_addr),
      .remaining_i (cur_len),
      .beats_o     (next_beats)
   );

   assign in_burst = (state == RD_END_LOCAL);

   // R feeds the stream directly, back-pressure included
   assign axis_data_o  = r_i.data;
   assign axis_valid_o = in_burst && rvalid_i;
   assign rready_o     = in_burst && axis_ready_i;

   assign r_done = in_burst && rvalid_i && axis_ready_i && r_i.last;

   assign cfg_ready_o = (state == RD_WAIT_START);

   assign arvalid_o   = (state == RD_TRANSFER);
   assign ar_o.addr   = cur_addr;
   assign ar_o.len    = axlen_t'(burst_beats - beats_t'(1));

   always_comb begin
      state_nxt = state;
      addr_nxt  = cur_addr;
      len_nxt   = cur_len;

      unique case (state)
         RD_WAIT_START: begin
            if (cfg_valid_i) begin
               addr_nxt = cfg_i.addr;
               len_nxt  = cfg_i.length;
               // Zero length stays idle
               if (cfg_i.length != '0) begin
                  state_nxt = RD_BEGIN_LOCAL;
               end
            end
         end
         RD_BEGIN_LOCAL: begin
            len_nxt   = cur_len - wcount_t'(next_beats);
            state_nxt = RD_TRANSFER;
         end
         RD_TRANSFER: begin
            if (arready_i) begin
               state_nxt = RD_END_LOCAL;
            end
         end
         RD_END_LOCAL: begin
            if (r_done) begin
               addr_nxt = cur_addr + addr_t'({burst_beats, 2'b00});
               if (cur_len == '0) begin
                  state_nxt = RD_WAIT_START;
               end else begin
                  state_nxt = RD_BEGIN_LOCAL;
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= RD_WAIT_START;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      cur_addr <= addr_nxt;
      cur_len  <= len_nxt;
      // Burst size held for AR and the address step
      if (state == RD_BEGIN_LOCAL) begin
         burst_beats <= next_beats;
      end
   end

endmodule

`default_nettype wire

// File: design/axi_burst_len.sv
`default_nettype none

module axi_burst_len
   import axis2axi_pkg::*;
(
   input  addr_t   addr_i,
   input  wcount_t remaining_i,
   output beats_t  beats_o
);

   wcount_t page_offset;
   wcount_t page_left;
   wcount_t limit;

   // Word offset inside the current 4 KB page
   assign page_offset = wcount_t'(addr_i[$clog2(PAGE_WORDS)+1:2]);

   // Words until the next boundary, 1 to PAGE_WORDS
   assign page_left = wcount_t'(PAGE_WORDS) - page_offset;

   always_comb begin
      limit = remaining_i;

      if (limit > wcount_t'(BURST_SIZE)) begin
         limit = wcount_t'(BURST_SIZE);
      end

      // Never run past the page end
      if (limit > page_left) begin
         limit = page_left;
      end
   end

   // limit is at most BURST_SIZE here so it fits
   assign beats_o = beats_t'(limit);

endmodule

`default_nettype wire

// File: design/axis2axi_pkg.sv
`default_nettype none

package axis2axi_pkg;

   localparam int ADDR_W     = 24;
   localparam int DATA_W     = 32;
   localparam int LEN_W      = 8;
   localparam int BURST_W    = 4;
   localparam int BURST_SIZE = 2 ** BURST_W;
   // 4 KB page of 4-byte words
   localparam int PAGE_WORDS = 1024;

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [ADDR_W-1:0]  wcount_t;
   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [BURST_W:0]   beats_t;
   typedef logic [LEN_W-1:0]   axlen_t;

   // Start byte address and length in words
   typedef struct packed {
      addr_t   addr;
      wcount_t length;
   } xfer_cfg_t;

   // AR or AW request, INCR with 4-byte beats
   typedef struct packed {
      addr_t  addr;
      axlen_t len;
   } axi_ax_t;

   // R or W beat
   typedef struct packed {
      data_t data;
      logic  last;
   } axi_beat_t;

   // Labels carry a prefix so both machines can share the package
   typedef enum logic [1:0] {
      RD_WAIT_START,
      RD_BEGIN_LOCAL,
      RD_TRANSFER,
      RD_END_LOCAL
   } rd_state_e;

   typedef enum logic [2:0] {
      WR_WAIT_START,
      WR_BEGIN_LOCAL,
      WR_ADDRESS,
      WR_DATA,
      WR_RESPONSE
   } wr_state_e;

endpackage

`default_nettype wire
